// File: rename_config_pkg.sv
/*
 * Architectural sizes of the rename subsystem and the mapping it starts from
 * after reset. Imported by the rename RTL and its testbench.
 */

package rename_config_pkg;

  localparam int arch_reg_count = 32;
  localparam int prf_count = 64;
  localparam int rename_width = 2;
  localparam int commit_width = 2;

  localparam int arch_index_bits = $clog2(arch_reg_count);
  localparam int prf_index_bits = $clog2(prf_count);

  // arch register i starts on physical register i, the upper half is free
  localparam int reset_free_count = prf_count - arch_reg_count;
  localparam logic [prf_count-1:0] reset_busy_mask =
    {{reset_free_count{1'b0}}, {arch_reg_count{1'b1}}};

endpackage

// File: rename_types_pkg.sv
/*
 * Register index, mask and per-slot vector types shared by the rename blocks.
 * Widths follow the sizes in the rename config package.
 */

package rename_types_pkg;

  // architectural and physical register indices
  typedef logic [rename_config_pkg::arch_index_bits-1:0] arch_reg_t;
  typedef logic [rename_config_pkg::prf_index_bits-1:0] phys_reg_t;

  // one bit per physical register, 1 means busy
  typedef logic [rename_config_pkg::prf_count-1:0] prf_mask_t;

  // free register count, one bit wider so that 64 fits
  typedef logic [rename_config_pkg::prf_index_bits:0] prf_count_t;

  // per-slot valid vectors of a rename group and a commit group
  typedef logic [rename_config_pkg::rename_width-1:0] rename_slots_t;
  typedef logic [rename_config_pkg::commit_width-1:0] commit_slots_t;

endpackage

// File: free_list.sv
/*
 * Physical register free list. Frees retired registers, then hands the lowest
 * free registers to the requesting rename slots in slot order.
 */

`timescale 1ns/1ps

module free_list (
  input  logic                                                           clock,
  input  logic                                                           reset,
  input  logic                                                           stall,
  input  logic                                                           recover,
  input  rename_types_pkg::rename_slots_t                                prf_req,
  input  rename_types_pkg::commit_slots_t                                prf_retire_valid,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::commit_width-1:0] prf_retire,
  input  rename_types_pkg::prf_mask_t                                    recover_mask,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] prf_alloc,
  output logic                                                           allocatable
);

  import rename_config_pkg::*;
  import rename_types_pkg::*;

  prf_mask_t  busy_mask;
  prf_count_t free_count;

  prf_mask_t  freed_mask;
  prf_count_t freed_count;
  prf_mask_t  alloc_mask;
  prf_count_t alloc_count;
  prf_count_t req_count;
  prf_count_t recover_count;

  // retirements come first, so their registers can be reallocated this cycle
  always_comb begin
    freed_mask  = busy_mask;
    freed_count = free_count;
    for (int s = 0; s < commit_width; s++) begin
      if (prf_retire_valid[s] && freed_mask[prf_retire[s]]) begin
        freed_mask[prf_retire[s]] = 1'b0;
        freed_count = freed_count + prf_count_t'(1);
      end
    end
  end

  always_comb begin
    req_count = '0;
    for (int s = 0; s < rename_width; s++) begin
      if (prf_req[s]) begin
        req_count = req_count + prf_count_t'(1);
      end
    end
  end

  // all or nothing, a group with no requests always passes
  assign allocatable = (req_count <= freed_count);

  always_comb begin
    alloc_mask  = freed_mask;
    alloc_count = freed_count;
    prf_alloc   = '0;
    if (allocatable) begin
      for (int s = 0; s < rename_width; s++) begin
        if (prf_req[s]) begin
          // downward scan, the last hit is the lowest free index
          for (int i = prf_count - 1; i >= 0; i--) begin
            if (!alloc_mask[i]) begin
              prf_alloc[s] = phys_reg_t'(i);
            end
          end
          alloc_mask[prf_alloc[s]] = 1'b1;
        end
      end
      alloc_count = freed_count - req_count;
    end
  end

  always_comb begin
    recover_count = '0;
    for (int i = 0; i < prf_count; i++) begin
      if (!recover_mask[i]) begin
        recover_count = recover_count + prf_count_t'(1);
      end
    end
  end

  // a stalled group allocates nothing, but retirements still land
  always_ff @(posedge clock) begin
    if (reset) begin
      busy_mask  <= reset_busy_mask;
      free_count <= prf_count_t'(reset_free_count);
    end else if (recover) begin
      busy_mask  <= recover_mask;
      free_count <= recover_count;
    end else if (stall) begin
      busy_mask  <= freed_mask;
      free_count <= freed_count;
    end else begin
      busy_mask  <= alloc_mask;
      free_count <= alloc_count;
    end
  end

endmodule

// File: map_table.sv
/*
 * Speculative architectural-to-physical map. Looks up sources and old
 * destinations of a rename group, with bypass from older slots in the group.
 */

`timescale 1ns/1ps

module map_table (
  input  logic                                                           clock,
  input  logic                                                           reset,
  input  logic                                                           stall,
  input  logic                                                           recover,
  input  rename_types_pkg::rename_slots_t                                rename_valid,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_dest,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_src1,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_src2,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] prf_alloc,
  input  logic                                                           allocatable,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::arch_reg_count-1:0] recover_map,
  output rename_types_pkg::rename_slots_t                                prf_req,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_src1,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_src2,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_dest,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] old_phys_dest
);

  import rename_config_pkg::*;
  import rename_types_pkg::*;

  phys_reg_t [arch_reg_count-1:0] spec_map;

  // x0 is never renamed, so it never asks for a register
  always_comb begin
    for (int s = 0; s < rename_width; s++) begin
      prf_req[s] = rename_valid[s] && (rename_dest[s] != '0);
    end
  end

  always_comb begin
    for (int s = 0; s < rename_width; s++) begin
      phys_src1[s]     = spec_map[rename_src1[s]];
      phys_src2[s]     = spec_map[rename_src2[s]];
      old_phys_dest[s] = spec_map[rename_dest[s]];
      // older slot writing the same arch register overrides the table
      for (int k = 0; k < s; k++) begin
        if (prf_req[k] && rename_dest[k] == rename_src1[s]) begin
          phys_src1[s] = prf_alloc[k];
        end
        if (prf_req[k] && rename_dest[k] == rename_src2[s]) begin
          phys_src2[s] = prf_alloc[k];
        end
        if (prf_req[k] && rename_dest[k] == rename_dest[s]) begin
          old_phys_dest[s] = prf_alloc[k];
        end
      end
      if (prf_req[s]) begin
        phys_dest[s] = prf_alloc[s];
      end else begin
        phys_dest[s]     = '0;
        old_phys_dest[s] = '0;
      end
    end
  end

  // later slot written last, so it wins on a shared destination
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_reg_count; i++) begin
        spec_map[i] <= phys_reg_t'(i);
      end
    end else if (recover) begin
      spec_map <= recover_map;
    end else if (allocatable && !stall) begin
      for (int s = 0; s < rename_width; s++) begin
        if (prf_req[s]) begin
          spec_map[rename_dest[s]] <= prf_alloc[s];
        end
      end
    end
  end

endmodule

// File: commit_map.sv
/*
 * Committed map and committed busy mask. Retires the registers replaced by
 * committing instructions and supplies the state that recovery reloads.
 */

`timescale 1ns/1ps

module commit_map (
  input  logic                                                           clock,
  input  logic                                                           reset,
  input  logic                                                           recover,
  input  rename_types_pkg::commit_slots_t                                commit_valid,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::commit_width-1:0] commit_arch,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::commit_width-1:0] commit_phys,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::commit_width-1:0] commit_old_phys,
  output rename_types_pkg::commit_slots_t                                prf_retire_valid,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::commit_width-1:0] prf_retire,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::arch_reg_count-1:0] recover_map,
  output rename_types_pkg::prf_mask_t                                    recover_mask
);

  import rename_config_pkg::*;
  import rename_types_pkg::*;

  phys_reg_t [arch_reg_count-1:0] commit_table;
  prf_mask_t                      committed_mask;
  phys_reg_t [arch_reg_count-1:0] table_next;
  prf_mask_t                      mask_next;

  // commits to x0 hold no register, and recover drops the whole group
  always_comb begin
    for (int s = 0; s < commit_width; s++) begin
      prf_retire_valid[s] = commit_valid[s] && (commit_arch[s] != '0) && !recover;
      prf_retire[s]       = commit_old_phys[s];
    end
  end

  // slot order matters when both slots commit the same arch register
  always_comb begin
    table_next = commit_table;
    mask_next  = committed_mask;
    for (int s = 0; s < commit_width; s++) begin
      if (prf_retire_valid[s]) begin
        table_next[commit_arch[s]]  = commit_phys[s];
        mask_next[commit_old_phys[s]] = 1'b0;
        mask_next[commit_phys[s]]     = 1'b1;
      end
    end
  end

  assign recover_map  = commit_table;
  assign recover_mask = committed_mask;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_reg_count; i++) begin
        commit_table[i] <= phys_reg_t'(i);
      end
      committed_mask <= reset_busy_mask;
    end else begin
      commit_table   <= table_next;
      committed_mask <= mask_next;
    end
  end

endmodule

// File: rename_top.sv
/*
 * Register rename subsystem top. Renames up to two instructions per cycle,
 * retires up to two per cycle and recovers to the committed state on request.
 */

`timescale 1ns/1ps

module rename_top (
  input  logic                                                           clock,
  input  logic                                                           reset,
  input  logic                                                           stall,
  input  logic                                                           recover,
  // rename group
  input  rename_types_pkg::rename_slots_t                                rename_valid,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_dest,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_src1,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_src2,
  output logic                                                           allocatable,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_dest,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_src1,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_src2,
  output rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] old_phys_dest,
  // commit group
  input  rename_types_pkg::commit_slots_t                                commit_valid,
  input  rename_types_pkg::arch_reg_t [rename_config_pkg::commit_width-1:0] commit_arch,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::commit_width-1:0] commit_phys,
  input  rename_types_pkg::phys_reg_t [rename_config_pkg::commit_width-1:0] commit_old_phys
);

  import rename_config_pkg::*;
  import rename_types_pkg::*;

  rename_slots_t                  prf_req;
  phys_reg_t [rename_width-1:0]   prf_alloc;
  commit_slots_t                  prf_retire_valid;
  phys_reg_t [commit_width-1:0]   prf_retire;
  phys_reg_t [arch_reg_count-1:0] recover_map;
  prf_mask_t                      recover_mask;

  map_table u_map_table (
    .clock         (clock),
    .reset         (reset),
    .stall         (stall),
    .recover       (recover),
    .rename_valid  (rename_valid),
    .rename_dest   (rename_dest),
    .rename_src1   (rename_src1),
    .rename_src2   (rename_src2),
    .prf_alloc     (prf_alloc),
    .allocatable   (allocatable),
    .recover_map   (recover_map),
    .prf_req       (prf_req),
    .phys_src1     (phys_src1),
    .phys_src2     (phys_src2),
    .phys_dest     (phys_dest),
    .old_phys_dest (old_phys_dest)
  );

  free_list u_free_list (
    .clock            (clock),
    .reset            (reset),
    .stall            (stall),
    .recover          (recover),
    .prf_req          (prf_req),
    .prf_retire_valid (prf_retire_valid),
    .prf_retire       (prf_retire),
    .recover_mask     (recover_mask),
    .prf_alloc        (prf_alloc),
    .allocatable      (allocatable)
  );

  commit_map u_commit_map (
    .clock            (clock),
    .reset            (reset),
    .recover          (recover),
    .commit_valid     (commit_valid),
    .commit_arch      (commit_arch),
    .commit_phys      (commit_phys),
    .commit_old_phys  (commit_old_phys),
    .prf_retire_valid (prf_retire_valid),
    .prf_retire       (prf_retire),
    .recover_map      (recover_map),
    .recover_mask     (recover_mask)
  );

endmodule

// File: rename_properties.sv
/*
 * Concurrent checks on the rename top level, attached with bind so the RTL
 * stays untouched. Checked on every rising clock edge outside of reset.
 */

`timescale 1ns/1ps

module rename_properties (
  input logic                                                           clock,
  input logic                                                           reset,
  input rename_types_pkg::rename_slots_t                                prf_req,
  input rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] prf_alloc,
  input logic                                                           allocatable,
  input rename_types_pkg::arch_reg_t [rename_config_pkg::rename_width-1:0] rename_dest,
  input rename_types_pkg::phys_reg_t [rename_config_pkg::rename_width-1:0] phys_dest
);

  import rename_config_pkg::*;
  import rename_types_pkg::*;

  // a group that asks for nothing can always go
  no_request_allocatable: assert property (
    @(posedge clock) disable iff (reset) (prf_req == '0) |-> allocatable
  ) else $error("allocatable low with no pending request");

  // both slots requesting must get distinct registers
  unique_alloc: assert property (
    @(posedge clock) disable iff (reset) (&prf_req && allocatable) |-> (prf_alloc[0] != prf_alloc[1])
  ) else $error("both slots received the same physical register");

  for (genvar s = 0; s < rename_width; s++) begin : g_x0_dest
    x0_dest_zero: assert property (
      @(posedge clock) disable iff (reset) (rename_dest[s] == '0) |-> (phys_dest[s] == '0)
    ) else $error("x0 destination renamed to a nonzero register");
  end

endmodule

bind rename_top rename_properties u_rename_properties (
  .clock       (clock),
  .reset       (reset),
  .prf_req     (prf_req),
  .prf_alloc   (prf_alloc),
  .allocatable (allocatable),
  .rename_dest (rename_dest),
  .phys_dest   (phys_dest)
);

// File: tb_rename.sv
/*
 * Testbench for the rename top level. Applies a table of rename, commit and
 * recover groups and compares the renamed registers with expected values.
 */

`timescale 1ns/1ps

module tb_rename;

  import rename_config_pkg::*;
  import rename_types_pkg::*;

  typedef enum {op_rename, op_recover} op_t;
  typedef arch_reg_t [rename_width-1:0] arch_pair_t;
  typedef phys_reg_t [rename_width-1:0] phys_pair_t;

  typedef struct {
    string         name;
    op_t           op;
    logic          stall;
    int            count;
    rename_slots_t valid;
    arch_pair_t    dest;
    arch_pair_t    src1;
    arch_pair_t    src2;
    commit_slots_t commit_valid;
    arch_pair_t    commit_arch;
    phys_pair_t    commit_phys;
    phys_pair_t    commit_old;
    logic          exp_alloc;
    phys_pair_t    exp_dest;
    phys_pair_t    exp_src1;
    phys_pair_t    exp_src2;
    phys_pair_t    exp_old;
  } row_t;

  localparam int reset_cycles  = 5;
  localparam int reset_timeout = 20;

  logic          clock;
  logic          reset;
  logic          stall;
  logic          recover;
  rename_slots_t rename_valid;
  arch_pair_t    rename_dest;
  arch_pair_t    rename_src1;
  arch_pair_t    rename_src2;
  logic          allocatable;
  phys_pair_t    phys_dest;
  phys_pair_t    phys_src1;
  phys_pair_t    phys_src2;
  phys_pair_t    old_phys_dest;
  commit_slots_t commit_valid;
  arch_pair_t    commit_arch;
  phys_pair_t    commit_phys;
  phys_pair_t    commit_old_phys;

  row_t table_rows[$];
  int   pass_count;
  int   fail_count;

  rename_top u_dut (
    .clock           (clock),
    .reset           (reset),
    .stall           (stall),
    .recover         (recover),
    .rename_valid    (rename_valid),
    .rename_dest     (rename_dest),
    .rename_src1     (rename_src1),
    .rename_src2     (rename_src2),
    .allocatable     (allocatable),
    .phys_dest       (phys_dest),
    .phys_src1       (phys_src1),
    .phys_src2       (phys_src2),
    .old_phys_dest   (old_phys_dest),
    .commit_valid    (commit_valid),
    .commit_arch     (commit_arch),
    .commit_phys     (commit_phys),
    .commit_old_phys (commit_old_phys)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset = 1'b0;
  end

  function automatic arch_pair_t arch_pair(input int s0, input int s1);
    arch_pair_t p;
    p[0] = arch_reg_t'(s0);
    p[1] = arch_reg_t'(s1);
    return p;
  endfunction

  function automatic phys_pair_t phys_pair(input int s0, input int s1);
    phys_pair_t p;
    p[0] = phys_reg_t'(s0);
    p[1] = phys_reg_t'(s1);
    return p;
  endfunction

  task automatic add_row(input string name, input op_t op, input logic stall_row, input int count,
                         input rename_slots_t valid, input arch_pair_t dest,
                         input arch_pair_t src1, input arch_pair_t src2);
    row_t r;
    r.name         = name;
    r.op           = op;
    r.stall        = stall_row;
    r.count        = count;
    r.valid        = valid;
    r.dest         = dest;
    r.src1         = src1;
    r.src2         = src2;
    r.commit_valid = '0;
    r.commit_arch  = '0;
    r.commit_phys  = '0;
    r.commit_old   = '0;
    r.exp_alloc    = 1'b1;
    r.exp_dest     = '0;
    r.exp_src1     = '0;
    r.exp_src2     = '0;
    r.exp_old      = '0;
    table_rows.push_back(r);
  endtask

  task automatic set_expected(input logic alloc, input phys_pair_t dest, input phys_pair_t src1,
                              input phys_pair_t src2, input phys_pair_t old);
    row_t r;
    r = table_rows.pop_back();
    r.exp_alloc = alloc;
    r.exp_dest  = dest;
    r.exp_src1  = src1;
    r.exp_src2  = src2;
    r.exp_old   = old;
    table_rows.push_back(r);
  endtask

  task automatic add_commit(input commit_slots_t valid, input arch_pair_t arch,
                            input phys_pair_t phys, input phys_pair_t old);
    row_t r;
    r = table_rows.pop_back();
    r.commit_valid = valid;
    r.commit_arch  = arch;
    r.commit_phys  = phys;
    r.commit_old   = old;
    table_rows.push_back(r);
  endtask

  task automatic build_table;
    // after reset x1..x31 map to themselves and 32 is the lowest free register
    add_row("reset_identity", op_rename, 1'b0, 1, 2'b11,
            arch_pair(5, 6), arch_pair(1, 3), arch_pair(2, 4));
    set_expected(1'b1, phys_pair(32, 33), phys_pair(1, 3), phys_pair(2, 4), phys_pair(5, 6));
    // slot 1 reads x7 that slot 0 of the same group writes
    add_row("bypass", op_rename, 1'b0, 1, 2'b11,
            arch_pair(7, 8), arch_pair(5, 7), arch_pair(6, 5));
    set_expected(1'b1, phys_pair(34, 35), phys_pair(32, 34), phys_pair(33, 32), phys_pair(7, 8));
    add_row("x0_dest", op_rename, 1'b0, 1, 2'b11,
            arch_pair(0, 9), arch_pair(7, 0), arch_pair(8, 6));
    set_expected(1'b1, phys_pair(0, 36), phys_pair(34, 0), phys_pair(35, 33), phys_pair(0, 9));
    add_row("stall_hold", op_rename, 1'b1, 1, 2'b11,
            arch_pair(9, 10), arch_pair(9, 9), arch_pair(8, 7));
    set_expected(1'b1, phys_pair(37, 38), phys_pair(36, 37), phys_pair(35, 34), phys_pair(36, 10));
    // the stalled group left x9 on 36 and registers 37 and 38 free
    add_row("after_stall", op_rename, 1'b0, 1, 2'b11,
            arch_pair(10, 11), arch_pair(9, 10), arch_pair(0, 9));
    set_expected(1'b1, phys_pair(37, 38), phys_pair(36, 37), phys_pair(0, 36), phys_pair(10, 11));
    // twelve groups take 39 to 62
    add_row("fill", op_rename, 1'b0, 12, 2'b11,
            arch_pair(10, 11), arch_pair(0, 0), arch_pair(0, 0));
    set_expected(1'b1, phys_pair(39, 40), phys_pair(0, 0), phys_pair(0, 0), phys_pair(37, 38));
    add_row("single_last", op_rename, 1'b0, 1, 2'b01,
            arch_pair(12, 0), arch_pair(10, 0), arch_pair(11, 0));
    set_expected(1'b1, phys_pair(63, 0), phys_pair(61, 0), phys_pair(62, 0), phys_pair(12, 0));
    add_row("exhausted", op_rename, 1'b0, 1, 2'b11,
            arch_pair(13, 14), arch_pair(12, 12), arch_pair(5, 1));
    set_expected(1'b0, phys_pair(0, 0), phys_pair(63, 63), phys_pair(32, 1), phys_pair(13, 14));
    add_row("exhausted_retry", op_rename, 1'b0, 1, 2'b11,
            arch_pair(13, 14), arch_pair(12, 12), arch_pair(5, 1));
    set_expected(1'b0, phys_pair(0, 0), phys_pair(63, 63), phys_pair(32, 1), phys_pair(13, 14));
    // retiring 5 and 6 frees them for the same cycle
    add_row("retire_reuse", op_rename, 1'b0, 1, 2'b11,
            arch_pair(13, 14), arch_pair(5, 13), arch_pair(6, 0));
    add_commit(2'b11, arch_pair(5, 6), phys_pair(32, 33), phys_pair(5, 6));
    set_expected(1'b1, phys_pair(5, 6), phys_pair(32, 5), phys_pair(33, 0), phys_pair(13, 14));
    add_row("recover", op_recover, 1'b0, 1, 2'b00,
            arch_pair(0, 0), arch_pair(0, 0), arch_pair(0, 0));
    set_expected(1'b1, phys_pair(0, 0), phys_pair(0, 0), phys_pair(0, 0), phys_pair(0, 0));
    // committed map has x5 on 32, x6 on 33 and x13 on 13
    add_row("after_recover", op_rename, 1'b0, 1, 2'b11,
            arch_pair(7, 8), arch_pair(5, 13), arch_pair(6, 10));
    set_expected(1'b1, phys_pair(5, 6), phys_pair(32, 13), phys_pair(33, 10), phys_pair(7, 8));
  endtask

  task automatic drive_idle;
    stall           = 1'b0;
    recover         = 1'b0;
    rename_valid    = '0;
    rename_dest     = '0;
    rename_src1     = '0;
    rename_src2     = '0;
    commit_valid    = '0;
    commit_arch     = '0;
    commit_phys     = '0;
    commit_old_phys = '0;
  endtask

  task automatic drive_row(input row_t r);
    stall           = r.stall;
    recover         = (r.op == op_recover);
    rename_valid    = r.valid;
    rename_dest     = r.dest;
    rename_src1     = r.src1;
    rename_src2     = r.src2;
    commit_valid    = r.commit_valid;
    commit_arch     = r.commit_arch;
    commit_phys     = r.commit_phys;
    commit_old_phys = r.commit_old;
  endtask

  task automatic check_phys(input string test, input string field, input phys_reg_t expected,
                            input phys_reg_t actual, inout int errs);
    assert (actual === expected) else begin
      $display("mismatch %s %s expected %0d actual %0d", test, field, expected, actual);
      errs++;
    end
  endtask

  task automatic check_outputs(input row_t r, input int k, inout int errs);
    phys_reg_t step;
    assert (allocatable === r.exp_alloc) else begin
      $display("mismatch %s allocatable expected %0b actual %0b", r.name, r.exp_alloc,
               allocatable);
      errs++;
    end
    // each repeat of a two-slot group takes the next two registers
    // and replaces the pair that the previous repeat took
    step = phys_reg_t'(2 * k);
    for (int s = 0; s < rename_width; s++) begin
      if (r.exp_alloc) begin
        check_phys(r.name, $sformatf("phys_dest[%0d]", s), r.exp_dest[s] + step,
                   phys_dest[s], errs);
      end
      check_phys(r.name, $sformatf("phys_src1[%0d]", s), r.exp_src1[s], phys_src1[s], errs);
      check_phys(r.name, $sformatf("phys_src2[%0d]", s), r.exp_src2[s], phys_src2[s], errs);
      check_phys(r.name, $sformatf("old_phys_dest[%0d]", s), r.exp_old[s] + step,
                 old_phys_dest[s], errs);
    end
  endtask

  task automatic run_row(input row_t r, output int errs);
    errs = 0;
    for (int k = 0; k < r.count; k++) begin
      @(posedge clock);
      #2;
      drive_row(r);
      // rename outputs are combinational and have settled by mid-cycle
      #8;
      check_outputs(r, k, errs);
    end
  endtask

  initial begin
    int waited;
    int errs;
    drive_idle();
    pass_count = 0;
    fail_count = 0;
    build_table();
    waited = 0;
    while (reset !== 1'b0 && waited < reset_timeout) begin
      @(posedge clock);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("reset still asserted after %0d cycles", reset_timeout);
      $display("TESTS FAILED");
    end else begin
      foreach (table_rows[i]) begin
        run_row(table_rows[i], errs);
        if (errs == 0) begin
          pass_count++;
          $display("test %s ok", table_rows[i].name);
        end else begin
          fail_count++;
          $display("test %s failed with %0d mismatches", table_rows[i].name, errs);
        end
      end
      @(posedge clock);
      #2;
      drive_idle();
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
    end
    $finish;
  end

endmodule

// File: src.f
rename_config_pkg.sv
rename_types_pkg.sv
free_list.sv
map_table.sv
commit_map.sv
rename_top.sv
rename_properties.sv
tb_rename.sv

// File: Makefile
# Verilator lint and simulation of the register rename subsystem

VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
TOP        := tb_rename
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TESTS FAILED
PASS_MSG   := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
